// File: all.f
+incdir+rtl
rtl/dmem_pkg.sv
rtl/dmem_ctrl.sv
rtl/dmem_agu.sv
rtl/dmem_data_route.sv
rtl/dmem_array.sv
rtl/dmem_body.sv
verif/dmem_clock_gen.sv
verif/dmem_tb.sv

// File: Makefile
# Verilator lint and simulation for the strided data memory
TOP = dmem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module dmem_body

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: verif/dmem_stimulus.txt
# op req base stride len gap data...   base, stride and len decimal, data words hex
# S and L wait until all earlier lines finish, s and l start together with the line above
S 1 10 3 8 0 11110000 11110001 11110002 11110003 11110004 11110005 11110006 11110007
L 2 10 3 8 0
S 1 40 1 4 0 22220000 22220001 22220002 22220003
s 2 50 1 4 0 33330000 33330001 33330002 33330003
L 1 40 1 4 0
l 2 50 1 4 0
S 2 100 2 8 1 4444a000 4444a001 4444a002 4444a003 4444a004 4444a005 4444a006 4444a007
L 1 100 2 8 1
L 2 100 2 8 0
S 1 252 1 8 0 5555b000 5555b001 5555b002 5555b003 5555b004 5555b005 5555b006 5555b007
L 2 252 1 8 0
S 2 246 3 4 1 5555c000 5555c001 5555c002 5555c003
L 1 252 1 8 1
S 1 200 1 8 1 6666d000 6666d001 6666d002 6666d003 6666d004 6666d005 6666d006 6666d007
l 2 10 3 8 1
L 1 200 1 8 0
S 2 60 7 1 0 77770000
L 1 60 7 1 0
L 1 10 3 8 1

// File: verif/dmem_tb.sv
// Testbench for the data memory top, runs the bursts in verif/dmem_stimulus.txt and checks loads
`default_nettype none

module dmem_tb;
	import dmem_pkg::*;

	localparam int max_cmds = 32;

	logic clock;
	logic reset;
	logic [3:0] req_d;		// Slot is channel*2 + requester, store channel first
	logic [3:0] valid_d;
	addr_t base_d [4];
	addr_t stride_d [4];
	len_t len_d [4];
	data_t st_data_d [2];
	logic st_grant1;
	logic st_grant2;
	logic ld_grant1;
	logic ld_grant2;
	data_t ld_data1;
	data_t ld_data2;
	logic ld_data_valid1;
	logic ld_data_valid2;

	logic cmd_load [max_cmds];
	logic cmd_par [max_cmds];		// Starts alongside the previous line
	int cmd_req [max_cmds];
	addr_t cmd_base [max_cmds];
	addr_t cmd_stride [max_cmds];
	len_t cmd_len [max_cmds];
	logic cmd_gap [max_cmds];
	data_t cmd_data [max_cmds*8];
	int n_cmds;
	int next_cmd;
	int cycle_limit;
	int cycles = 0;
	int seed;
	data_t model_mem [256];
	data_t exp_q1 [$];
	data_t exp_q2 [$];
	int phase [4];		// 0 idle, 1 requesting, 2 granted, 3 waiting for release
	int slot_cmd [4];
	int remain [4];
	int word_idx [4];
	addr_t next_addr [4];
	int served [2];		// Last winner per channel

	dmem_clock_gen i_clock_gen (
		.clock(clock)
	);

	dmem_body i_dmem_body (
		.clock(clock),
		.reset(reset),
		.st_req1(req_d[0]),
		.st_req2(req_d[1]),
		.st_base1(base_d[0]),
		.st_base2(base_d[1]),
		.st_stride1(stride_d[0]),
		.st_stride2(stride_d[1]),
		.st_len1(len_d[0]),
		.st_len2(len_d[1]),
		.st_valid1(valid_d[0]),
		.st_valid2(valid_d[1]),
		.st_data1(st_data_d[0]),
		.st_data2(st_data_d[1]),
		.st_grant1(st_grant1),
		.st_grant2(st_grant2),
		.ld_req1(req_d[2]),
		.ld_req2(req_d[3]),
		.ld_base1(base_d[2]),
		.ld_base2(base_d[3]),
		.ld_stride1(stride_d[2]),
		.ld_stride2(stride_d[3]),
		.ld_len1(len_d[2]),
		.ld_len2(len_d[3]),
		.ld_valid1(valid_d[2]),
		.ld_valid2(valid_d[3]),
		.ld_grant1(ld_grant1),
		.ld_grant2(ld_grant2),
		.ld_data1(ld_data1),
		.ld_data2(ld_data2),
		.ld_data_valid1(ld_data_valid1),
		.ld_data_valid2(ld_data_valid2)
	);

	//////////////////////////////////////////////////
	// Failure reporting
	//////////////////////////////////////////////////

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("ERROR: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus file
	//////////////////////////////////////////////////

	task automatic read_stimulus();
		int fd;
		int code;
		logic [63:0] op_tok;
		logic [8*256-1:0] rest;
		int req;
		int base;
		int stride;
		int len;
		int gap;
		logic [31:0] word;
		fd = $fopen("verif/dmem_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_failure("The stimulus file verif/dmem_stimulus.txt could not be opened");
		end
		n_cmds = 0;
		cycle_limit = 0;
		while (!$feof(fd)) begin
			op_tok = '0;
			code = $fscanf(fd, "%s", op_tok);
			if (code != 1) begin
				break;
			end
			if (op_tok == "#") begin
				code = $fgets(rest, fd);	// Column notes
				continue;
			end
			code = $fscanf(fd, "%d %d %d %d %d", req, base, stride, len, gap);
			if (code != 5 || req < 1 || req > 2 || len < 1 || n_cmds >= max_cmds) begin
				stop_with_failure("A stimulus line has missing or out-of-range fields");
			end
			cmd_load[n_cmds] = (op_tok == "L" || op_tok == "l");
			cmd_par[n_cmds] = (op_tok == "s" || op_tok == "l");
			cmd_req[n_cmds] = req - 1;
			cmd_base[n_cmds] = addr_t'(base);
			cmd_stride[n_cmds] = addr_t'(stride);
			cmd_len[n_cmds] = len_t'(len);
			cmd_gap[n_cmds] = (gap != 0);
			if (!cmd_load[n_cmds]) begin
				if (len > 8) begin
					stop_with_failure("A store line asks for more than eight words");
				end
				for (int k = 0; k < len; k++) begin
					code = $fscanf(fd, "%h", word);
					if (code != 1) begin
						stop_with_failure("A store line has fewer data words than its length");
					end
					cmd_data[n_cmds*8 + k] = word;
				end
			end
			cycle_limit += 40 + 4*len;
			n_cmds++;
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Burst engine
	//////////////////////////////////////////////////

	function automatic logic all_idle();
		logic idle;
		idle = (exp_q1.size() == 0) && (exp_q2.size() == 0);
		for (int s = 0; s < 4; s++) begin
			idle = idle && (phase[s] == 0);
		end
		return idle;
	endfunction

	task automatic issue_commands();
		int s;
		logic go;
		go = 1'b1;
		while (go && next_cmd < n_cmds) begin
			s = (cmd_load[next_cmd] ? 2 : 0) + cmd_req[next_cmd];
			if (cmd_par[next_cmd] ? (phase[s] == 0) : all_idle()) begin
				phase[s] = 1;
				slot_cmd[s] = next_cmd;
				remain[s] = int'(cmd_len[next_cmd]);
				word_idx[s] = 0;
				next_addr[s] = cmd_base[next_cmd];
				base_d[s] = cmd_base[next_cmd];	// Held until the next command
				stride_d[s] = cmd_stride[next_cmd];
				len_d[s] = cmd_len[next_cmd];
				next_cmd++;
			end else begin
				go = 1'b0;
			end
		end
	endtask

	task automatic run_cycle();
		logic [3:0] g;
		int ch;
		int r;
		int k;
		logic v;
		g = {ld_grant2, ld_grant1, st_grant2, st_grant1};
		if (ld_data_valid1) begin
			if (exp_q1.size() == 0) begin
				stop_with_failure("Requester 1 received load data it never asked for");
			end
			check_value("load data requester 1", exp_q1.pop_front(), ld_data1);
		end
		if (ld_data_valid2) begin
			if (exp_q2.size() == 0) begin
				stop_with_failure("Requester 2 received load data it never asked for");
			end
			check_value("load data requester 2", exp_q2.pop_front(), ld_data2);
		end
		for (int c = 0; c < 2; c++) begin
			check_value("one grant per channel", 0, g[c*2] & g[c*2+1]);
		end
		for (int s = 0; s < 4; s++) begin
			ch = s / 2;
			r = s % 2;
			case (phase[s])
				0: check_value("grant without request", 0, g[s]);
				1: begin
					if (g[s]) begin
						if (req_d[s^1]) begin	// Both asked on this channel
							check_value("arbitration winner", (served[ch] == 0) ? 1 : 0, r);
						end
						served[ch] = r;
						phase[s] = 2;
					end
				end
				2: check_value("grant held during burst", 1, g[s]);
				default: begin
					check_value("grant release after last beat", 0, g[s]);
					phase[s] = 0;
				end
			endcase
		end
		issue_commands();
		// Loads first, reads see the word from before a same-cycle store
		for (int s = 3; s >= 0; s--) begin
			v = 1'b0;
			if (phase[s] == 2) begin
				k = slot_cmd[s];
				v = cmd_gap[k] ? (($random(seed) % 2) != 0) : 1'b1;
				if (v) begin
					if (s == 2) begin
						exp_q1.push_back(model_mem[next_addr[s]]);
					end else if (s == 3) begin
						exp_q2.push_back(model_mem[next_addr[s]]);
					end else begin
						st_data_d[s] = cmd_data[k*8 + word_idx[s]];
						model_mem[next_addr[s]] = cmd_data[k*8 + word_idx[s]];
					end
					next_addr[s] = next_addr[s] + stride_d[s];	// Wraps at 256
					word_idx[s]++;
					remain[s]--;
					if (remain[s] == 0) begin
						phase[s] = 3;
					end
				end
			end
			valid_d[s] = v;
			req_d[s] = (phase[s] == 1);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			stop_with_failure($sformatf("Timeout: the run did not finish in %0d cycles",
				cycle_limit));
		end
	end

	initial begin
		seed = 6588;
		reset = 1'b1;
		req_d = '0;
		valid_d = '0;
		st_data_d[0] = '0;
		st_data_d[1] = '0;
		for (int s = 0; s < 4; s++) begin
			base_d[s] = '0;
			stride_d[s] = '0;
			len_d[s] = '0;
			phase[s] = 0;
		end
		served[0] = 1;		// Requester 1 first after reset
		served[1] = 1;
		next_cmd = 0;
		read_stimulus();
		repeat (10) begin
			@(posedge clock);
			#1;
			check_value("grants in reset", 0, {ld_grant2, ld_grant1, st_grant2, st_grant1});
			check_value("load valid in reset", 0, {ld_data_valid2, ld_data_valid1});
		end
		reset = 1'b0;
		do begin
			@(posedge clock);
			#1;
			run_cycle();
		end while (next_cmd < n_cmds || !all_idle());
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/dmem_clock_gen.sv
// Free-running testbench clock, 8 time units per period
`default_nettype none

module dmem_clock_gen (
	output logic clock
);

	initial begin
		clock = 1'b0;
	end

	always #4 clock = ~clock;	// Half period

endmodule

`default_nettype wire

// File: rtl/dmem_body.sv
// Top of the strided data memory, wires arbiter, AGUs, routing and storage together
`default_nettype none

module dmem_body (
	input wire logic clock,
	input wire logic reset,
	input wire logic st_req1,
	input wire logic st_req2,
	input dmem_pkg::addr_t st_base1,
	input dmem_pkg::addr_t st_base2,
	input dmem_pkg::addr_t st_stride1,
	input dmem_pkg::addr_t st_stride2,
	input dmem_pkg::len_t st_len1,
	input dmem_pkg::len_t st_len2,
	input wire logic st_valid1,
	input wire logic st_valid2,
	input dmem_pkg::data_t st_data1,
	input dmem_pkg::data_t st_data2,
	output logic st_grant1,
	output logic st_grant2,
	input wire logic ld_req1,
	input wire logic ld_req2,
	input dmem_pkg::addr_t ld_base1,
	input dmem_pkg::addr_t ld_base2,
	input dmem_pkg::addr_t ld_stride1,
	input dmem_pkg::addr_t ld_stride2,
	input dmem_pkg::len_t ld_len1,
	input dmem_pkg::len_t ld_len2,
	input wire logic ld_valid1,
	input wire logic ld_valid2,
	output logic ld_grant1,
	output logic ld_grant2,
	output dmem_pkg::data_t ld_data1,
	output dmem_pkg::data_t ld_data2,
	output logic ld_data_valid1,
	output logic ld_data_valid2
);
	import dmem_pkg::*;

	req_sel_t st_owner;
	req_sel_t ld_owner;
	logic st_start;
	logic ld_start;
	logic st_last;
	logic ld_last;
	logic st_beat;		// Write enable
	logic ld_beat;		// Read enable
	addr_t st_address;
	addr_t ld_address;
	data_t wr_data;
	data_t rd_data;

	//////////////////////////////////////////////////
	// Arbitration
	//////////////////////////////////////////////////

	dmem_ctrl i_dmem_ctrl (
		.clock(clock),
		.reset(reset),
		.st_req1(st_req1),
		.st_req2(st_req2),
		.ld_req1(ld_req1),
		.ld_req2(ld_req2),
		.st_last(st_last),
		.ld_last(ld_last),
		.st_grant1(st_grant1),
		.st_grant2(st_grant2),
		.ld_grant1(ld_grant1),
		.ld_grant2(ld_grant2),
		.st_start(st_start),
		.ld_start(ld_start),
		.st_owner(st_owner),
		.ld_owner(ld_owner)
	);

	//////////////////////////////////////////////////
	// Address generation
	//////////////////////////////////////////////////

	dmem_agu agu_st (
		.clock(clock),
		.reset(reset),
		.start(st_start),
		.owner(st_owner),
		.base1(st_base1),
		.base2(st_base2),
		.stride1(st_stride1),
		.stride2(st_stride2),
		.len1(st_len1),
		.len2(st_len2),
		.valid1(st_valid1),
		.valid2(st_valid2),
		.address(st_address),
		.beat(st_beat),
		.last(st_last)
	);

	dmem_agu agu_ld (
		.clock(clock),
		.reset(reset),
		.start(ld_start),
		.owner(ld_owner),
		.base1(ld_base1),
		.base2(ld_base2),
		.stride1(ld_stride1),
		.stride2(ld_stride2),
		.len1(ld_len1),
		.len2(ld_len2),
		.valid1(ld_valid1),
		.valid2(ld_valid2),
		.address(ld_address),
		.beat(ld_beat),
		.last(ld_last)
	);

	//////////////////////////////////////////////////
	// Data path and storage
	//////////////////////////////////////////////////

	dmem_data_route i_dmem_data_route (
		.clock(clock),
		.reset(reset),
		.st_owner(st_owner),
		.ld_owner(ld_owner),
		.st_data1(st_data1),
		.st_data2(st_data2),
		.ld_beat(ld_beat),
		.rd_data(rd_data),
		.wr_data(wr_data),
		.ld_data1(ld_data1),
		.ld_data2(ld_data2),
		.ld_data_valid1(ld_data_valid1),
		.ld_data_valid2(ld_data_valid2)
	);

	dmem_array i_dmem_array (
		.clock(clock),
		.wr_en(st_beat),
		.wr_addr(st_address),
		.rd_addr(ld_address),
		.wr_data(wr_data),
		.rd_en(ld_beat),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: rtl/dmem_array.sv
// Word storage with one write port and one registered, read-first read port
`default_nettype none

module dmem_array (
	input wire logic clock,
	input wire logic wr_en,
	input dmem_pkg::addr_t wr_addr,
	input dmem_pkg::addr_t rd_addr,
	input dmem_pkg::data_t wr_data,
	input wire logic rd_en,
	output dmem_pkg::data_t rd_data
);
	import dmem_pkg::*;

	localparam int depth = 2 ** $bits(addr_t);	// Every address is backed

	data_t mem [depth];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Same-cycle write to rd_addr is not visible until the next read
	always_ff @(posedge clock) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// File: rtl/dmem_data_route.sv
// Steers store data into the memory and load data back to the owning requester
`default_nettype none

module dmem_data_route (
	input wire logic clock,
	input wire logic reset,
	input dmem_pkg::req_sel_t st_owner,
	input dmem_pkg::req_sel_t ld_owner,
	input dmem_pkg::data_t st_data1,
	input dmem_pkg::data_t st_data2,
	input wire logic ld_beat,
	input dmem_pkg::data_t rd_data,
	output dmem_pkg::data_t wr_data,
	output dmem_pkg::data_t ld_data1,
	output dmem_pkg::data_t ld_data2,
	output logic ld_data_valid1,
	output logic ld_data_valid2
);
	import dmem_pkg::*;

	logic beat_q;			// Read issued last cycle
	req_sel_t rd_owner_q;	// Who that read belongs to

	//////////////////////////////////////////////////
	// Store side
	//////////////////////////////////////////////////

	assign wr_data = (st_owner == req_two) ? st_data2 : st_data1;

	//////////////////////////////////////////////////
	// Load return
	//////////////////////////////////////////////////

	// Owner is tracked alongside the read so the word lands correctly even when
	// the grant has already moved to the other requester
	always_ff @(posedge clock) begin
		if (reset) begin
			beat_q <= 1'b0;
			rd_owner_q <= req_one;
		end else begin
			beat_q <= ld_beat;
			if (ld_beat) begin
				rd_owner_q <= ld_owner;
			end
		end
	end

	assign ld_data_valid1 = beat_q & (rd_owner_q == req_one);
	assign ld_data_valid2 = beat_q & (rd_owner_q == req_two);
	assign ld_data1 = ld_data_valid1 ? rd_data : '0;	// Idle port reads zero
	assign ld_data2 = ld_data_valid2 ? rd_data : '0;

endmodule

`default_nettype wire

// File: rtl/dmem_agu.sv
// Strided address generator, one per channel, stepping through a granted burst
`default_nettype none

module dmem_agu (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input dmem_pkg::req_sel_t owner,
	input dmem_pkg::addr_t base1,
	input dmem_pkg::addr_t base2,
	input dmem_pkg::addr_t stride1,
	input dmem_pkg::addr_t stride2,
	input dmem_pkg::len_t len1,
	input dmem_pkg::len_t len2,
	input wire logic valid1,
	input wire logic valid2,
	output dmem_pkg::addr_t address,
	output logic beat,
	output logic last
);
	import dmem_pkg::*;

	addr_t addr_q;		// Next word address
	addr_t stride_q;
	len_t cnt_q;		// Words left in the burst
	addr_t cur_addr;
	addr_t cur_stride;
	len_t cur_cnt;
	logic sel_valid;

	// The descriptor is still on the inputs during the start cycle, so a beat there
	// runs straight from it instead of waiting for the registers
	assign cur_addr = start ? ((owner == req_two) ? base2 : base1) : addr_q;
	assign cur_stride = start ? ((owner == req_two) ? stride2 : stride1) : stride_q;
	assign cur_cnt = start ? ((owner == req_two) ? len2 : len1) : cnt_q;
	assign sel_valid = (owner == req_two) ? valid2 : valid1;

	assign beat = sel_valid & (cur_cnt != '0);
	assign last = beat & (cur_cnt == len_t'(1));
	assign address = cur_addr;

	always_ff @(posedge clock) begin
		if (reset) begin
			cnt_q <= '0;
		end else if (beat) begin
			cnt_q <= len_t'(cur_cnt - len_t'(1));
		end else if (start) begin
			cnt_q <= cur_cnt;
		end
	end

	always_ff @(posedge clock) begin
		if (beat) begin
			addr_q <= addr_t'(cur_addr + cur_stride);	// Wraps at memory depth
		end else if (start) begin
			addr_q <= cur_addr;
		end
		if (start) begin
			stride_q <= cur_stride;
		end
	end

endmodule

`default_nettype wire

// File: rtl/dmem_ctrl.sv
// Channel arbiter for the data memory, grants one requester per channel per burst
`default_nettype none

module dmem_ctrl (
	input wire logic clock,
	input wire logic reset,
	input wire logic st_req1,
	input wire logic st_req2,
	input wire logic ld_req1,
	input wire logic ld_req2,
	input wire logic st_last,
	input wire logic ld_last,
	output logic st_grant1,
	output logic st_grant2,
	output logic ld_grant1,
	output logic ld_grant2,
	output logic st_start,
	output logic ld_start,
	output dmem_pkg::req_sel_t st_owner,
	output dmem_pkg::req_sel_t ld_owner
);
	import dmem_pkg::*;

	// Index 0 is the store channel, index 1 the load channel
	logic [1:0] req_a;
	logic [1:0] req_b;
	logic [1:0] last_in;
	logic [1:0] grant_a;
	logic [1:0] grant_b;
	logic [1:0] start_out;
	req_sel_t owner_out [2];

	assign req_a = {ld_req1, st_req1};
	assign req_b = {ld_req2, st_req2};
	assign last_in = {ld_last, st_last};

	//////////////////////////////////////////////////
	// Per-channel burst FSM with round-robin pointer
	//////////////////////////////////////////////////

	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		logic busy_q;		// Burst in progress
		logic start_q;		// First grant cycle
		req_sel_t owner_q;
		req_sel_t served_q;	// Winner of the previous grant
		req_sel_t pick;

		always_comb begin
			if (req_a[ch] & req_b[ch]) begin
				pick = (served_q == req_one) ? req_two : req_one;	// Alternate on contention
			end else if (req_a[ch]) begin
				pick = req_one;
			end else begin
				pick = req_two;
			end
		end

		always_ff @(posedge clock) begin
			if (reset) begin
				busy_q <= 1'b0;
				start_q <= 1'b0;
				owner_q <= req_one;
				served_q <= req_two;	// Requester 1 wins first
			end else begin
				start_q <= 1'b0;
				if (busy_q) begin
					if (last_in[ch]) begin
						busy_q <= 1'b0;		// Release after final beat
					end
				end else if (req_a[ch] | req_b[ch]) begin
					busy_q <= 1'b1;
					start_q <= 1'b1;
					owner_q <= pick;
					served_q <= pick;
				end
			end
		end

		assign grant_a[ch] = busy_q & (owner_q == req_one);
		assign grant_b[ch] = busy_q & (owner_q == req_two);
		assign start_out[ch] = start_q;
		assign owner_out[ch] = owner_q;
	end

	assign st_grant1 = grant_a[0];
	assign st_grant2 = grant_b[0];
	assign ld_grant1 = grant_a[1];
	assign ld_grant2 = grant_b[1];
	assign st_start = start_out[0];
	assign ld_start = start_out[1];
	assign st_owner = owner_out[0];
	assign ld_owner = owner_out[1];

endmodule

`default_nettype wire

// File: rtl/dmem_pkg.sv
// Shared types for the data memory tile; modules import it inside their bodies
`default_nettype none

`include "dmem_config.svh"

package dmem_pkg;

	//////////////////////////////////////////////////
	// Address, payload and burst length
	//////////////////////////////////////////////////

	typedef logic [`DMEM_ADDR_W-1:0] addr_t;	// Word address, also the stride
	typedef logic [`DMEM_DATA_W-1:0] data_t;	// One memory word
	typedef logic [`DMEM_LEN_W-1:0] len_t;		// Words per burst, never zero

	//////////////////////////////////////////////////
	// Requester select
	//////////////////////////////////////////////////

	typedef enum logic {
		req_one = 1'b0,		// Requester 1
		req_two = 1'b1		// Requester 2
	} req_sel_t;

endpackage

`default_nettype wire

// File: rtl/dmem_config.svh
// Sizing macros for the strided data memory, pulled in by the shared package
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

//////////////////////////////////////////////////
// Memory geometry
//////////////////////////////////////////////////

`define DMEM_ADDR_W 8		// Word address bits, 256 words
`define DMEM_DATA_W 32		// Bits per memory word

//////////////////////////////////////////////////
// Burst descriptor
//////////////////////////////////////////////////

// One extra bit over the address so a single burst can sweep every word
`define DMEM_LEN_W 9

`endif
